// ==== Makefile ====
SOURCES := $(shell cat filelist.f)

obj_dir/VpongTb: $(SOURCES) filelist.f
	verilator --binary --timing --assert --top-module pongTb -f filelist.f

.PHONY: run clean

run: obj_dir/VpongTb
	./obj_dir/VpongTb | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== ballMotion.sv ====
`timescale 1ns/1ps

module ballMotion
#(
	parameter int BallSize = 30,
	parameter int PaddleHeight = 60
)
(
	input  logic clock,
	input  logic arstN,
	input  logic ballStep,
	input  logic playing,
	input  logic newGame,
	input  pongPkg::directionT serveDir,
	courtIf.motion court,
	output logic pointP1,
	output logic pointP2
);
	import pongPkg::*;

	localparam coordT BallSpan = coordT'(BallSize - 1);
	localparam coordT PaddleSpan = coordT'(PaddleHeight - 1);

	coordT ballX;
	coordT ballY;
	coordT ballRight;
	coordT ballBottom;
	directionT dir;
	directionT nextDir;
	logic servePending;
	logic movingLeft;
	logic movingDown;
	logic missLeft;
	logic missRight;
	logic hitWall;
	logic hitPaddle1;
	logic hitPaddle2;

	// Ball rows against the rows of one paddle
	function automatic logic rowsOverlap(input coordT paddleTop, input coordT ballTop);
		return (ballTop <= paddleTop + PaddleSpan) && (ballTop + BallSpan >= paddleTop);
	endfunction

	assign ballRight = ballX + BallSpan;
	assign ballBottom = ballY + BallSpan;
	assign movingLeft = dir[1];
	assign movingDown = dir[0];

	assign missLeft = movingLeft && (ballX == '0);
	assign missRight = !movingLeft && (ballRight == ScreenWidth - 1'b1);

	assign hitWall = movingDown ? (ballBottom == BottomWall - 1'b1) : (ballY == TopWall);

	assign hitPaddle1 = movingLeft && (ballX == Paddle1Right + 1'b1)
		&& rowsOverlap(court.paddle1Top, ballY);
	assign hitPaddle2 = !movingLeft && (ballRight == Paddle2Left - 1'b1)
		&& rowsOverlap(court.paddle2Top, ballY);

	// A bounce mirrors only the axis that was hit
	assign nextDir = directionT'({movingLeft ^ (hitPaddle1 | hitPaddle2), movingDown ^ hitWall});

	assign court.ballX = ballX;
	assign court.ballY = ballY;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			ballX <= ServeX;
			ballY <= ServeY;
			dir <= upRight;
			servePending <= 1'b1;
			pointP1 <= 1'b0;
			pointP2 <= 1'b0;
		end
		else
		begin
			pointP1 <= 1'b0;
			pointP2 <= 1'b0;
			if (newGame)
			begin
				servePending <= 1'b1;
			end
			else if (ballStep && playing)
			begin
				if (servePending)
				begin
					ballX <= ServeX;
					ballY <= ServeY;
					dir <= serveDir;
					servePending <= 1'b0;
				end
				else if (missLeft)
				begin
					pointP2 <= 1'b1;    // Left edge reached
					servePending <= 1'b1;
				end
				else if (missRight)
				begin
					pointP1 <= 1'b1;
					servePending <= 1'b1;
				end
				else
				begin
					dir <= nextDir;
					ballX <= nextDir[1] ? ballX - 1'b1 : ballX + 1'b1;
					ballY <= nextDir[0] ? ballY + 1'b1 : ballY - 1'b1;
				end
			end
		end
	end

endmodule

// ==== courtIf.sv ====
`timescale 1ns/1ps

interface courtIf;
	import pongPkg::*;

	coordT ballX;    // Top-left corner of the ball
	coordT ballY;
	coordT paddle1Top;
	coordT paddle2Top;

	modport motion
	(
		output ballX,
		output ballY,
		input  paddle1Top,
		input  paddle2Top
	);

	modport render
	(
		input ballX,
		input ballY,
		input paddle1Top,
		input paddle2Top
	);

endinterface

// ==== filelist.f ====
pongPkg.sv
courtIf.sv
vgaTiming.sv
ballMotion.sv
scoreKeeper.sv
pixelRenderer.sv
pongTop.sv
tbClock.sv
pongTop_sva.sv
pongTb.sv

// ==== pixelRenderer.sv ====
`timescale 1ns/1ps

module pixelRenderer
#(
	parameter int BallSize = 30,
	parameter int PaddleHeight = 60
)
(
	input  logic clock,
	input  logic arstN,
	input  pongPkg::coordT hCount,
	input  pongPkg::coordT vCount,
	courtIf.render court,
	output logic red,
	output logic green,
	output logic blue
);
	import pongPkg::*;

	localparam coordT BallSpan = coordT'(BallSize - 1);
	localparam coordT PaddleSpan = coordT'(PaddleHeight - 1);

	logic onPaddle1;
	logic onPaddle2;
	logic onBall;
	logic white;

	function automatic logic inRange(input coordT value, input coordT low, input coordT high);
		return (value >= low) && (value <= high);
	endfunction

	assign onPaddle1 = inRange(hCount, Paddle1Left, Paddle1Right)
		&& inRange(vCount, court.paddle1Top, court.paddle1Top + PaddleSpan);
	assign onPaddle2 = inRange(hCount, Paddle2Left, Paddle2Right)
		&& inRange(vCount, court.paddle2Top, court.paddle2Top + PaddleSpan);
	assign onBall = inRange(hCount, court.ballX, court.ballX + BallSpan)
		&& inRange(vCount, court.ballY, court.ballY + BallSpan);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			white <= 1'b0;
		else
			white <= onPaddle1 | onPaddle2 | onBall;    // Aligned with hsync and vsync
	end

	assign red = white;
	assign green = white;
	assign blue = white;

endmodule

// ==== pongPkg.sv ====
package pongPkg;

	typedef logic [10:0] coordT;    // Pixel coordinate or count
	typedef logic [3:0] scoreT;

	// Bit 1 marks leftward motion and bit 0 downward motion
	typedef enum logic [1:0] {
		upRight   = 2'b00,
		downRight = 2'b01,
		upLeft    = 2'b10,
		downLeft  = 2'b11
	} directionT;

	typedef enum logic [1:0] {
		idle    = 2'b00,
		playing = 2'b01,
		over    = 2'b10
	} gameStateT;

	localparam coordT HTotal = 11'd800;
	localparam coordT VTotal = 11'd525;
	localparam coordT HSyncStart = 11'd656;
	localparam coordT HSyncEnd = 11'd752;    // First column after the pulse
	localparam coordT VSyncStart = 11'd490;
	localparam coordT VSyncEnd = 11'd492;

	localparam coordT TopWall = 11'd5;
	localparam coordT BottomWall = 11'd475;
	localparam coordT ScreenWidth = 11'd640;

	localparam coordT Paddle1Left = 11'd5;
	localparam coordT Paddle1Right = 11'd35;
	localparam coordT Paddle2Left = 11'd605;
	localparam coordT Paddle2Right = 11'd635;

	localparam coordT ServeX = 11'd320;
	localparam coordT ServeY = 11'd240;

endpackage

// ==== pongTb.sv ====
`timescale 1ns/1ps

module pongTb;
	import pongPkg::*;

	localparam int BallSize = 30;
	localparam int PaddleHeight = 60;
	localparam int Parked = 1000;    // Paddle rows below the screen

	logic clock;
	logic arstN;
	logic ballStep;
	logic start;
	logic red;
	logic green;
	logic blue;
	logic hsync;
	logic vsync;
	logic gameOn;
	coordT paddle1Top;
	coordT paddle2Top;
	directionT serveDir;
	scoreT score1;
	scoreT score2;
	int errorCount = 0;
	int testCount = 0;

	tbClock i_tbClock (.clock(clock), .arstN(arstN));

	pongTop #(.BallSize(BallSize), .PaddleHeight(PaddleHeight), .WinScore(10)) i_pongTop
	(
		.clock(clock), .arstN(arstN), .paddle1Top(paddle1Top), .paddle2Top(paddle2Top),
		.ballStep(ballStep), .start(start), .serveDir(serveDir), .red(red), .green(green),
		.blue(blue), .hsync(hsync), .vsync(vsync), .score1(score1), .score2(score2),
		.gameOn(gameOn)
	);

	task automatic checkValue(input string name, input int actual, input int expected);
		assert (actual == expected)
		else
		begin
			$display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
			errorCount++;
		end
	endtask

	task automatic endTest(input string title);
		testCount++;
		$display("Test %0d %s done, errors so far %0d", testCount, title, errorCount);
	endtask

	// Ball model from the serve to the step that scores
	function automatic int predictPoint(input logic [1:0] dir, input int p1, input int p2,
		output int winner, output int row2);
		int x;
		int y;
		int n;
		logic left;
		logic down;
		logic flipX;
		x = 320;
		y = 240;
		left = dir[1];
		down = dir[0];
		row2 = -1;
		winner = 0;
		for (n = 2; n < 100000; n++)
		begin
			if (left && x == 0)
			begin
				winner = 2;
				return n;
			end
			if (!left && x + BallSize - 1 == 639)
			begin
				winner = 1;
				return n;
			end
			if (down ? (y + BallSize - 1 == 474) : (y == 5))
				down = !down;
			if (!left && x + BallSize - 1 == 604 && row2 < 0)
				row2 = y;    // First arrival at the paddle 2 face
			flipX = left ? (x == 36 && y <= p1 + PaddleHeight - 1 && y + BallSize - 1 >= p1)
				: (x + BallSize - 1 == 604 && y <= p2 + PaddleHeight - 1 && y + BallSize - 1 >= p2);
			if (flipX)
				left = !left;
			x = left ? x - 1 : x + 1;
			y = down ? y + 1 : y - 1;
		end
		return n;
	endfunction

	task automatic doStep();
		@(negedge clock) ballStep = 1'b1;
		@(negedge clock) ballStep = 1'b0;
		repeat (2) @(negedge clock);
	endtask

	task automatic startGame();
		@(negedge clock) start = 1'b1;
		@(negedge clock) start = 1'b0;
		repeat (3) @(negedge clock);
	endtask

	// Steps until a score moves and compares with the model
	task automatic playRally(input directionT dir, input int p2);
		int n;
		int k;
		int winner;
		int row2;
		int s1;
		int s2;
		n = predictPoint(dir, Parked, p2, winner, row2);
		s1 = int'(score1);
		s2 = int'(score2);
		@(negedge clock) serveDir = dir;
		k = 0;
		do
		begin
			doStep();
			k++;
		end
		while (int'(score1) == s1 && int'(score2) == s2 && k < n + 5);
		checkValue("point step", k, n);
		checkValue("score1", int'(score1), s1 + (winner == 1 ? 1 : 0));
		checkValue("score2", int'(score2), s2 + (winner == 2 ? 1 : 0));
	endtask

	initial
	begin
		repeat (3000000) @(posedge clock);
		$display("Watchdog expired before the tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		int bx;
		int by;
		int hFalls;
		int vFalls;
		int white;
		int lit;
		int lastFall;
		int winner;
		int row2;
		logic prevH;
		logic prevV;
		paddle1Top = coordT'(100);
		paddle2Top = coordT'(300);
		ballStep = 1'b0;
		start = 1'b0;
		serveDir = upRight;
		void'($urandom(32'h30c0));
		@(posedge arstN);
		repeat (3) @(negedge clock);

		checkValue("gameOn", int'(gameOn), 0);
		checkValue("score1", int'(score1), 0);
		checkValue("score2", int'(score2), 0);
		bx = int'(i_pongTop.i_ballMotion.ballX);
		by = int'(i_pongTop.i_ballMotion.ballY);
		repeat (5) doStep();
		checkValue("ballX", int'(i_pongTop.i_ballMotion.ballX), bx);
		checkValue("ballY", int'(i_pongTop.i_ballMotion.ballY), by);
		endTest("idle after reset");

		hFalls = 0;
		vFalls = 0;
		white = 0;
		lit = 0;
		lastFall = -1;
		prevH = hsync;
		prevV = vsync;
		for (int c = 0; c < 420000; c++)
		begin
			@(negedge clock);
			if (prevH && !hsync)
			begin
				if (lastFall >= 0)
					checkValue("hsync fall interval", c - lastFall, 800);
				lastFall = c;
				hFalls++;
			end
			if (prevV && !vsync)
				vFalls++;
			if (red && green && blue)
				white++;
			if (red || green || blue)
				lit++;    // Any colour on, so a lone colour shows up here
			prevH = hsync;
			prevV = vsync;
		end
		checkValue("hsync falls", hFalls, 525);
		checkValue("vsync falls", vFalls, 1);
		checkValue("white cycles", white, 2 * 31 * PaddleHeight + BallSize * BallSize);
		checkValue("lit cycles", lit, 2 * 31 * PaddleHeight + BallSize * BallSize);
		endTest("raster frame");

		paddle1Top = coordT'(Parked);
		paddle2Top = coordT'(Parked);
		startGame();
		checkValue("gameOn", int'(gameOn), 1);
		for (int i = 0; i < 10; i++)
			playRally(directionT'({1'b0, 1'($urandom)}), Parked);
		checkValue("gameOn", int'(gameOn), 0);
		bx = int'(i_pongTop.i_ballMotion.ballX);
		repeat (4) doStep();
		checkValue("score1", int'(score1), 10);
		checkValue("score2", int'(score2), 0);
		checkValue("ballX", int'(i_pongTop.i_ballMotion.ballX), bx);
		startGame();
		checkValue("gameOn", int'(gameOn), 1);
		checkValue("score1", int'(score1), 0);
		checkValue("score2", int'(score2), 0);
		endTest("game over and restart");

		playRally(directionT'({1'b0, 1'($urandom)}), Parked);
		playRally(directionT'({1'b1, 1'($urandom)}), Parked);
		endTest("serve scoring");

		void'(predictPoint(upRight, Parked, Parked, winner, row2));
		paddle2Top = coordT'(row2);    // Right in the ball's path
		playRally(upRight, row2);
		checkValue("score1", int'(score1), 1);
		endTest("paddle bounce");

		if (errorCount == 0)
		begin
			$display("%0d tests, 0 errors", testCount);
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("%0d tests, %0d errors", testCount, errorCount);
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== pongTop.sv ====
`timescale 1ns/1ps

module pongTop
#(
	parameter int BallSize = 30,
	parameter int PaddleHeight = 60,
	parameter int WinScore = 10
)
(
	input  logic clock,
	input  logic arstN,
	input  pongPkg::coordT paddle1Top,
	input  pongPkg::coordT paddle2Top,
	input  logic ballStep,
	input  logic start,
	input  pongPkg::directionT serveDir,
	output logic red,
	output logic green,
	output logic blue,
	output logic hsync,
	output logic vsync,
	output pongPkg::scoreT score1,
	output pongPkg::scoreT score2,
	output logic gameOn
);
	import pongPkg::*;

	coordT hCount;
	coordT vCount;
	logic pointP1;
	logic pointP2;
	logic playing;
	logic newGame;

	courtIf court();

	assign court.paddle1Top = paddle1Top;
	assign court.paddle2Top = paddle2Top;

	vgaTiming i_vgaTiming
	(
		.clock(clock),
		.arstN(arstN),
		.hCount(hCount),
		.vCount(vCount),
		.hsync(hsync),
		.vsync(vsync)
	);

	ballMotion #(.BallSize(BallSize), .PaddleHeight(PaddleHeight)) i_ballMotion
	(
		.clock(clock),
		.arstN(arstN),
		.ballStep(ballStep),
		.playing(playing),
		.newGame(newGame),
		.serveDir(serveDir),
		.court(court.motion),
		.pointP1(pointP1),
		.pointP2(pointP2)
	);

	scoreKeeper #(.WinScore(WinScore)) i_scoreKeeper
	(
		.clock(clock),
		.arstN(arstN),
		.start(start),
		.pointP1(pointP1),
		.pointP2(pointP2),
		.score1(score1),
		.score2(score2),
		.playing(playing),
		.newGame(newGame),
		.gameOn(gameOn)
	);

	pixelRenderer #(.BallSize(BallSize), .PaddleHeight(PaddleHeight)) i_pixelRenderer
	(
		.clock(clock),
		.arstN(arstN),
		.hCount(hCount),
		.vCount(vCount),
		.court(court.render),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

// ==== pongTop_sva.sv ====
`timescale 1ns/1ps

module pongTopSva
(
	input logic clock,
	input logic arstN,
	input logic hsync,
	input logic start,
	input logic gameOn,
	input pongPkg::scoreT score1,
	input pongPkg::scoreT score2
);
	// Sync pulse is 96 columns wide
	hsyncWidthFall: assert property (@(posedge clock) disable iff (!arstN)
		$fell(hsync) |-> ##95 !hsync ##1 hsync)
		else $error("hsync low pulse did not last 96 cycles");
	hsyncWidthRise: assert property (@(posedge clock) disable iff (!arstN)
		$rose(hsync) |-> ($past(hsync, 97) && !$past(hsync, 96)))
		else $error("hsync rose without a 96 cycle low pulse");

	scoreLimit: assert property (@(posedge clock) disable iff (!arstN)
		(score1 <= 4'd10) && (score2 <= 4'd10))
		else $error("score above 10");

	score1Step: assert property (@(posedge clock) disable iff (!arstN)
		(score1 != $past(score1)) |->
		((score1 == $past(score1) + 4'd1) || (score1 == 4'd0 && $past(start))))
		else $error("score1 changed by more than one point");
	score2Step: assert property (@(posedge clock) disable iff (!arstN)
		(score2 != $past(score2)) |->
		((score2 == $past(score2) + 4'd1) || (score2 == 4'd0 && $past(start))))
		else $error("score2 changed by more than one point");

	overAtWin: assert property (@(posedge clock) disable iff (!arstN)
		(score1 == 4'd10 || score2 == 4'd10) |-> !gameOn)
		else $error("gameOn high with a winning score");

endmodule

bind pongTop pongTopSva i_pongTopSva
(
	.clock(clock),
	.arstN(arstN),
	.hsync(hsync),
	.start(start),
	.gameOn(gameOn),
	.score1(score1),
	.score2(score2)
);

// ==== scoreKeeper.sv ====
`timescale 1ns/1ps

module scoreKeeper
#(
	parameter int WinScore = 10
)
(
	input  logic clock,
	input  logic arstN,
	input  logic start,
	input  logic pointP1,
	input  logic pointP2,
	output pongPkg::scoreT score1,
	output pongPkg::scoreT score2,
	output logic playing,
	output logic newGame,
	output logic gameOn
);
	import pongPkg::*;

	localparam scoreT LastPoint = scoreT'(WinScore - 1);

	gameStateT state;
	logic winP1;
	logic winP2;

	assign winP1 = pointP1 && (score1 == LastPoint);
	assign winP2 = pointP2 && (score2 == LastPoint);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= idle;
			score1 <= '0;
			score2 <= '0;
			newGame <= 1'b0;
		end
		else
		begin
			newGame <= 1'b0;
			case (state)
				pongPkg::playing:
				begin
					if (pointP1)
						score1 <= score1 + 1'b1;
					if (pointP2)
						score2 <= score2 + 1'b1;
					if (winP1 || winP2)
						state <= over;    // Ball freezes from here
				end
				default:    // Idle or over, waiting for start
				begin
					if (start)
					begin
						score1 <= '0;
						score2 <= '0;
						newGame <= 1'b1;
						state <= pongPkg::playing;
					end
				end
			endcase
		end
	end

	assign playing = (state == pongPkg::playing);
	assign gameOn = playing;

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock
(
	output logic clock,
	output logic arstN
);
	initial
	begin
		clock = 1'b0;
		forever #50 clock = !clock;    // 100 ns period
	end

	initial
	begin
		arstN = 1'b0;
		repeat (5) @(posedge clock);
		@(negedge clock) arstN = 1'b1;
	end

endmodule

// ==== vgaTiming.sv ====
`timescale 1ns/1ps

module vgaTiming
(
	input  logic clock,
	input  logic arstN,
	output pongPkg::coordT hCount,
	output pongPkg::coordT vCount,
	output logic hsync,
	output logic vsync
);
	import pongPkg::*;

	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (hCount == HTotal - 1'b1);
	assign frameEnd = (vCount == VTotal - 1'b1);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (lineEnd)
		begin
			hCount <= '0;
			vCount <= frameEnd ? '0 : vCount + 1'b1;    // Line advances on wrap
		end
		else
		begin
			hCount <= hCount + 1'b1;
		end
	end

	// Active low pulses, one cycle behind the counters like the colour
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			hsync <= 1'b1;
			vsync <= 1'b1;
		end
		else
		begin
			hsync <= !(hCount >= HSyncStart && hCount < HSyncEnd);
			vsync <= !(vCount >= VSyncStart && vCount < VSyncEnd);
		end
	end

endmodule
